// File: serial_out.f
+incdir+design
design/serial_out_pkg.sv
design/fifo.sv
design/serial_tx.sv
design/serial_out.sv
testbench/serial_out_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

TOP=serial_out_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	-f serial_out.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi

// File: testbench/serial_out_tb.sv
// needs timing support in the simulator, both clocks free run and the run stops at the first mismatch
`timescale 1ns/1ps
`include "serial_out_defines.svh"

module serial_out_tb;
	import serial_out_pkg::*;

	// frame length in line bits and in remove-clock samples
	localparam int frame_bits = `SO_WORD_BITS + 2;
	localparam int frame_samples = frame_bits * `SO_BIT_CYCLES;
	localparam int depth = 2 ** `SO_ADDR_BITS;

	// bytes per test, hold test keeps only depth of them
	localparam int paced_bytes = 20;
	localparam int hold_bytes = depth + 2;
	localparam int total_frames = paced_bytes + depth + depth;

	// about 55 insert cycles per frame, paced bytes at least 60 apart
	localparam int frame_cycles = 55;
	localparam int gap_cycles = 60;
	localparam int timeout_cycles = 2 * (40 * frame_cycles + paced_bytes * gap_cycles) + 1200;

	logic in_rst;
	logic in_clk_insert;
	logic in_clk_remove;
	logic in_insert;
	word_t in_data;
	logic in_hold;
	wr_status_t out_status;
	logic out_serial;
	logic out_busy;

	// accepted bytes whose frame has not started yet
	word_t exp_q[$];
	logic ovf_model;
	logic hold_on;
	logic rx_active;
	logic gap_check;
	int idle_run;
	int rx_count;
	int cycle_cnt;
	logic [31:0] rng_state;

	serial_out UUT (
		.in_rst        (in_rst),
		.in_clk_insert (in_clk_insert),
		.in_clk_remove (in_clk_remove),
		.in_insert     (in_insert),
		.in_data       (in_data),
		.out_status    (out_status),
		.in_hold       (in_hold),
		.out_serial    (out_serial),
		.out_busy      (out_busy)
	);

	// ----------------------------------------------------------------------
	// clocks and run limit
	// ----------------------------------------------------------------------

	initial begin
		in_clk_insert = 1'b0;
		forever #10 in_clk_insert = ~in_clk_insert;
	end

	// 26 ns, no remove rising edge ever lands on an insert edge
	initial begin
		in_clk_remove = 1'b0;
		forever #13 in_clk_remove = ~in_clk_remove;
	end

	always @(posedge in_clk_insert) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("timeout: no end of test within %0d insert cycles", timeout_cycles);
			stop_with_failure();
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// expected line levels in send order, start bit at index 0
	function automatic logic [frame_bits-1:0] frame_of(input word_t b);
		logic [frame_bits-1:0] f;
		f[0] = 1'b0;
		for (int i = 0; i < `SO_WORD_BITS; i++) begin
			f[i + 1] = b[i];
		end
		f[frame_bits-1] = 1'b1;
		return f;
	endfunction

	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// one strobe, called on an insert falling edge, returns on the next one
	task automatic insert_byte(input word_t b);
		in_insert = 1'b1;
		in_data = b;
		// dropped when every slot holds unsent data
		if (exp_q.size() < depth) begin
			exp_q.push_back(b);
		end else begin
			ovf_model = 1'b1;
		end
		@(negedge in_clk_insert);
		in_insert = 1'b0;
	endtask

	task automatic insert_random();
		rng_state = lcg_next(rng_state);
		insert_byte(rng_state[23:16]);
	endtask

	task automatic check_status(input logic exp_full, input logic exp_ovf);
		assert (out_status.full == exp_full) else begin
			$display("ERR out_status.full: got %h expected %h", out_status.full, exp_full);
			stop_with_failure();
		end
		assert (out_status.overflow == exp_ovf) else begin
			$display("ERR out_status.overflow: got %h expected %h",
				out_status.overflow, exp_ovf);
			stop_with_failure();
		end
	endtask

	// line high, no frame
	task automatic check_line_idle();
		assert (out_serial == 1'b1) else begin
			$display("ERR out_serial: got %h expected %h", out_serial, 1'b1);
			stop_with_failure();
		end
		assert (out_busy == 1'b0) else begin
			$display("ERR out_busy: got %h expected %h", out_busy, 1'b0);
			stop_with_failure();
		end
	endtask

	// all modelled bytes sent and the transmitter back in idle
	task automatic wait_drained();
		@(negedge in_clk_remove);
		while (exp_q.size() != 0 || rx_active || out_busy) begin
			@(negedge in_clk_remove);
		end
	endtask

	// ----------------------------------------------------------------------
	// frame receiver
	// ----------------------------------------------------------------------

	initial begin : receiver
		word_t exp_byte;
		logic [frame_bits-1:0] exp_frame;
		int i;
		@(negedge in_rst);
		forever begin
			@(negedge out_serial);
			assert (!hold_on) else begin
				$display("a frame started on out_serial while in_hold was high");
				stop_with_failure();
			end
			assert (exp_q.size() != 0) else begin
				$display("a frame started on out_serial with no accepted byte left");
				stop_with_failure();
			end
			exp_byte = exp_q.pop_front();
			exp_frame = frame_of(exp_byte);
			rx_active = 1'b1;
			// every remove cycle of every bit, so bit length is checked too
			for (i = 0; i < frame_samples; i++) begin
				@(negedge in_clk_remove);
				assert (out_serial == exp_frame[i / `SO_BIT_CYCLES]) else begin
					$display("ERR out_serial: byte %h sample %h got %h expected %h",
						exp_byte, i, out_serial, exp_frame[i / `SO_BIT_CYCLES]);
					stop_with_failure();
				end
			end
			rx_count = rx_count + 1;
			rx_active = 1'b0;
		end
	end

	// busy low between burst frames only briefly
	always @(negedge in_clk_remove) begin
		if (gap_check && exp_q.size() != 0 && !out_busy) begin
			idle_run = idle_run + 1;
		end else begin
			idle_run = 0;
		end
		assert (idle_run <= 3) else begin
			$display("ERR out_busy: low for %h remove cycles, limit %h", idle_run, 3);
			stop_with_failure();
		end
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------

	initial begin : stimulus
		int n;
		in_rst = 1'b1;
		in_insert = 1'b0;
		in_data = '0;
		in_hold = 1'b0;
		ovf_model = 1'b0;
		hold_on = 1'b0;
		rx_active = 1'b0;
		gap_check = 1'b0;
		idle_run = 0;
		rx_count = 0;
		cycle_cnt = 0;
		rng_state = 32'd39;
		repeat (8) @(posedge in_clk_insert);
		@(negedge in_clk_insert);
		in_rst = 1'b0;

		// reset values until the first insert
		repeat (12) begin
			@(negedge in_clk_insert);
			check_line_idle();
			check_status(1'b0, 1'b0);
		end

		// paced bytes, buffer never fills
		for (n = 0; n < paced_bytes; n++) begin
			insert_random();
			repeat (gap_cycles + int'(rng_state[26:24])) @(negedge in_clk_insert);
		end
		wait_drained();

		// back to back burst of one full buffer
		@(negedge in_clk_insert);
		for (n = 0; n < depth; n++) begin
			insert_random();
		end
		@(negedge in_clk_remove);
		while (!out_busy) begin
			@(negedge in_clk_remove);
		end
		gap_check = 1'b1;
		wait_drained();
		gap_check = 1'b0;

		// hold, fill past full
		in_hold = 1'b1;
		hold_on = 1'b1;
		@(negedge in_clk_insert);
		for (n = 0; n < hold_bytes; n++) begin
			insert_random();
			check_status(exp_q.size() == depth, ovf_model);
		end
		repeat (2 * frame_samples) begin
			@(negedge in_clk_remove);
			check_line_idle();
		end
		in_hold = 1'b0;
		hold_on = 1'b0;
		wait_drained();
		@(negedge in_clk_insert);
		check_status(1'b0, 1'b1);

		// drain, no extra frame
		repeat (200) begin
			@(negedge in_clk_remove);
			check_line_idle();
		end

		if (rx_count == total_frames && exp_q.size() == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("ERR rx_count: got %h expected %h", rx_count, total_frames);
			stop_with_failure();
		end
	end

endmodule

// File: design/serial_out.sv
// latency from insert to start bit varies with clock phase, in_hold only delays the next frame
`timescale 1ns/1ps
`include "serial_out_defines.svh"

module serial_out (
	input  logic                       in_rst,
	input  logic                       in_clk_insert,
	input  logic                       in_clk_remove,
	// insert domain
	input  logic                       in_insert,
	input  serial_out_pkg::word_t      in_data,
	output serial_out_pkg::wr_status_t out_status,
	// remove domain
	input  logic                       in_hold,
	output logic                       out_serial,
	output logic                       out_busy
);
	import serial_out_pkg::*;

	// ----------------------------------------------------------------------
	// fifo to transmitter
	// ----------------------------------------------------------------------

	// oldest word and empty flag, remove domain
	rd_port_t rd_port;

	// one strobe per frame
	logic pop;

	// two-clock buffer
	fifo u_fifo (
		.in_rst        (in_rst),
		.in_clk_insert (in_clk_insert),
		.in_clk_remove (in_clk_remove),
		.in_insert     (in_insert),
		.in_data       (in_data),
		.in_pop        (pop),
		.out_rd        (rd_port),
		.out_status    (out_status)
	);

	// frame shifter
	serial_tx u_tx (
		.in_rst        (in_rst),
		.in_clk_remove (in_clk_remove),
		.in_hold       (in_hold),
		.in_rd         (rd_port),
		.out_pop       (pop),
		.out_serial    (out_serial),
		.out_busy      (out_busy)
	);

endmodule

// File: design/serial_tx.sv
// no parity and no receiver, one frame is start, SO_WORD_BITS data bits LSB first and one stop bit
`timescale 1ns/1ps
`include "serial_out_defines.svh"

module serial_tx (
	input  logic                     in_rst,
	input  logic                     in_clk_remove,
	input  logic                     in_hold,
	input  serial_out_pkg::rd_port_t in_rd,
	output logic                     out_pop,
	output logic                     out_serial,
	output logic                     out_busy
);
	import serial_out_pkg::*;

	// last count values of both counters
	localparam bitcnt_t last_cycle = bitcnt_t'(`SO_BIT_CYCLES - 1);
	localparam bitcnt_t last_bit = bitcnt_t'(`SO_WORD_BITS - 1);

	// ----------------------------------------------------------------------
	// state
	// ----------------------------------------------------------------------

	tx_state_e state;
	bitcnt_t cyc_cnt;
	bitcnt_t bit_cnt;
	word_t shift_q;
	logic serial_q;
	logic bit_end;

	// pop straight from idle, hold only blocks a new frame
	assign out_pop = (state == tx_idle) && !in_rd.empty && !in_hold;

	// last cycle of the current bit
	assign bit_end = (cyc_cnt == last_cycle);

	assign out_serial = serial_q;
	assign out_busy = (state != tx_idle);

	// ----------------------------------------------------------------------
	// shift register
	// ----------------------------------------------------------------------

	// loaded on pop, shifted after start and each data bit
	always_ff @(posedge in_clk_remove) begin
		if (out_pop) begin
			shift_q <= in_rd.data;
		end else if (bit_end && (state == tx_start || state == tx_data)) begin
			shift_q <= shift_q >> 1;
		end
	end

	// ----------------------------------------------------------------------
	// FSM and counters
	// ----------------------------------------------------------------------

	always_ff @(posedge in_clk_remove) begin
		if (in_rst) begin
			state <= tx_idle;
			cyc_cnt <= '0;
			bit_cnt <= '0;
			serial_q <= 1'b1;
		end else begin
			// bit-cycle counter runs in every frame state
			if (state == tx_idle || bit_end) begin
				cyc_cnt <= '0;
			end else begin
				cyc_cnt <= bitcnt_t'(cyc_cnt + 1'b1);
			end

			case (state)
				tx_idle: begin
					bit_cnt <= '0;
					// start bit goes out with the state change
					if (out_pop) begin
						state <= tx_start;
						serial_q <= 1'b0;
					end
				end
				tx_start: begin
					if (bit_end) begin
						state <= tx_data;
						serial_q <= shift_q[0];
					end
				end
				tx_data: begin
					if (bit_end) begin
						bit_cnt <= bitcnt_t'(bit_cnt + 1'b1);
						if (bit_cnt == last_bit) begin
							// stop bit
							state <= tx_stop;
							serial_q <= 1'b1;
						end else begin
							// shift_q already moved on by one
							serial_q <= shift_q[0];
						end
					end
				end
				tx_stop: begin
					// line stays high into idle
					if (bit_end) begin
						state <= tx_idle;
					end
				end
				default: begin
					state <= tx_idle;
					serial_q <= 1'b1;
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	// line idles high between frames
	a_idle_line_high: assert property (@(posedge in_clk_remove) disable iff (in_rst)
		(state == tx_idle) |-> out_serial);

	// one pop per frame
	a_pop_single: assert property (@(posedge in_clk_remove) disable iff (in_rst)
		out_pop |=> !out_pop);

endmodule

// File: design/fifo.sv
// full may stay high a few insert cycles after a pop and in_rst must span several cycles of both clocks
`timescale 1ns/1ps
`include "serial_out_defines.svh"

module fifo (
	input  logic                       in_rst,
	input  logic                       in_clk_insert,
	input  logic                       in_clk_remove,
	input  logic                       in_insert,
	input  serial_out_pkg::word_t      in_data,
	input  logic                       in_pop,
	output serial_out_pkg::rd_port_t   out_rd,
	output serial_out_pkg::wr_status_t out_status
);
	import serial_out_pkg::*;

	localparam int num_words = 2 ** `SO_ADDR_BITS;
	localparam int top_bit = `SO_ADDR_BITS;

	// ----------------------------------------------------------------------
	// storage and pointers
	// ----------------------------------------------------------------------

	// buffer memory, written on insert clock only
	word_t mem [num_words];

	// insert domain
	ptr_t fp;
	ptr_t fp_next;
	ptr_t fp_gray;
	ptr_t [`SO_SYNC_STAGES-1:0] bp_sync;
	ptr_t bp_far;
	ptr_t full_cmp;
	logic accept;
	logic full_q;
	logic ovf_q;

	// remove domain
	ptr_t bp;
	ptr_t bp_next;
	ptr_t bp_gray;
	ptr_t [`SO_SYNC_STAGES-1:0] fp_sync;
	logic empty;

	// binary to gray, one bit changes per step
	function automatic ptr_t bin2gray(input ptr_t b);
		return b ^ (b >> 1);
	endfunction

	// ----------------------------------------------------------------------
	// insert side
	// ----------------------------------------------------------------------

	// drop the insert when full
	assign accept = in_insert & ~full_q;
	assign fp_next = accept ? ptr_t'(fp + 1'b1) : fp;

	// back pointer after the last sync stage
	assign bp_far = bp_sync[`SO_SYNC_STAGES-1];

	// full pattern in gray: top two bits inverted, rest equal
	assign full_cmp = {~bp_far[top_bit:top_bit-1], bp_far[top_bit-2:0]};

	always_ff @(posedge in_clk_insert) begin
		if (accept) begin
			mem[fp[`SO_ADDR_BITS-1:0]] <= in_data;
		end
	end

	always_ff @(posedge in_clk_insert) begin
		if (in_rst) begin
			fp <= '0;
			fp_gray <= '0;
			bp_sync <= '0;
			full_q <= 1'b0;
			ovf_q <= 1'b0;
		end else begin
			fp <= fp_next;
			// registered gray copy, the only thing the remove side sees
			fp_gray <= bin2gray(fp_next);
			bp_sync <= {bp_sync[`SO_SYNC_STAGES-2:0], bp_gray};
			// rises on the edge that takes the last free slot
			full_q <= (bin2gray(fp_next) == full_cmp);
			// sticky until reset
			if (in_insert && full_q) begin
				ovf_q <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// remove side
	// ----------------------------------------------------------------------

	// empty when our pointer catches the synchronised front
	assign empty = (bp_gray == fp_sync[`SO_SYNC_STAGES-1]);

	// pop while empty is ignored
	assign bp_next = (in_pop && !empty) ? ptr_t'(bp + 1'b1) : bp;

	always_ff @(posedge in_clk_remove) begin
		if (in_rst) begin
			bp <= '0;
			bp_gray <= '0;
			fp_sync <= '0;
		end else begin
			bp <= bp_next;
			bp_gray <= bin2gray(bp_next);
			fp_sync <= {fp_sync[`SO_SYNC_STAGES-2:0], fp_gray};
		end
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------

	// combinational read at the back pointer
	assign out_rd.data = mem[bp[`SO_ADDR_BITS-1:0]];
	assign out_rd.empty = empty;

	assign out_status.full = full_q;
	assign out_status.overflow = ovf_q;

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	// the transmitter only pops when it has seen data
	a_no_pop_empty: assert property (@(posedge in_clk_remove) disable iff (in_rst)
		in_pop |-> !empty);

	// a buffer that is really full keeps its front pointer on the next edge
	a_no_advance_full: assert property (@(posedge in_clk_insert) disable iff (in_rst)
		(bin2gray(fp) == full_cmp) |=> $stable(fp));

endmodule

// File: design/serial_out_pkg.sv
// widths follow the defines header so a change there needs a rebuild of every file using these types
`include "serial_out_defines.svh"

package serial_out_pkg;

	// ----------------------------------------------------------------------
	// plain vectors
	// ----------------------------------------------------------------------

	// one data byte
	typedef logic [`SO_WORD_BITS-1:0] word_t;

	// buffer pointer with one extra wrap bit
	typedef logic [`SO_ADDR_BITS:0] ptr_t;

	// bit-cycle and data-bit counters
	typedef logic [3:0] bitcnt_t;

	// ----------------------------------------------------------------------
	// grouped signals
	// ----------------------------------------------------------------------

	// remove side view of the buffer
	typedef struct packed {
		word_t data;
		logic  empty;
	} rd_port_t;

	// insert side status, both bits registered
	typedef struct packed {
		logic full;
		logic overflow;
	} wr_status_t;

	// transmitter FSM
	typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;

endpackage

// File: design/serial_out_defines.svh
// depth must stay a power of two with at least four words and SO_BIT_CYCLES must not exceed 16
`ifndef SERIAL_OUT_DEFINES_SVH
`define SERIAL_OUT_DEFINES_SVH

// ----------------------------------------------------------------------
// data path
// ----------------------------------------------------------------------

// bits per buffered word and per serial frame payload
`define SO_WORD_BITS 8

// buffer address bits, depth is 2**SO_ADDR_BITS
`define SO_ADDR_BITS 3

// ----------------------------------------------------------------------
// timing
// ----------------------------------------------------------------------

// remove-clock cycles per serial bit
`define SO_BIT_CYCLES 4

// flops in each pointer synchroniser
`define SO_SYNC_STAGES 2

`endif
